// ==== design/issue_pkg.sv ====
//--------------------------------------
// shared types for the issue stage: register addresses,
// function units, producer tags, row ages and row states
//--------------------------------------
`default_nettype none

package issue_pkg;

    // architectural register count
    localparam int NUM_REGS = 32;

    typedef logic [4:0] reg_addr_t;

    // function unit, also the fust row index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_e;

    // 0 means ready, otherwise the producing unit plus one
    typedef logic [1:0] tag_t;

    typedef logic [1:0] age_t;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

endpackage

`default_nettype wire

// ==== design/regfile.sv ====
//--------------------------------------
// register file, two read ports and one write port
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile import issue_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              wen,
    input  reg_addr_t         wsel,
    input  logic [DATA_W-1:0] wdata,
    input  reg_addr_t         rsel1,
    input  reg_addr_t         rsel2,
    output logic [DATA_W-1:0] rdat1,
    output logic [DATA_W-1:0] rdat2
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK or negedge nRST) begin : reg_write
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    // r0 reads zero, a same-cycle write is forwarded
    always_comb begin : read_port1
        rdat1 = regs[rsel1];
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && wsel == rsel1) begin
            rdat1 = wdata;
        end
    end

    always_comb begin : read_port2
        rdat2 = regs[rsel2];
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && wsel == rsel2) begin
            rdat2 = wdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_status.sv ====
//--------------------------------------
// register status table, names the pending producer of each
// register and hands source tags to dispatch
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_status import issue_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      disp_en,
    input  fu_e       disp_fu,
    input  reg_addr_t disp_rd,
    input  reg_addr_t disp_rs1,
    input  reg_addr_t disp_rs2,
    input  logic      done_en,
    input  fu_e       done_fu,
    output tag_t      src_t1,
    output tag_t      src_t2
);

    tag_t status [NUM_REGS];
    tag_t disp_tag;
    tag_t done_tag;
    tag_t raw_t1;
    tag_t raw_t2;
    logic set_en;

    assign disp_tag = tag_t'(disp_fu) + tag_t'(1);
    assign done_tag = tag_t'(done_fu) + tag_t'(1);

    // branches write no register, r0 is never pending
    assign set_en = disp_en && disp_rd != '0 &&
                    (disp_fu == FU_ALU || disp_fu == FU_LDST);

    always_ff @(posedge CLK or negedge nRST) begin : status_update
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                status[i] <= '0;
            end
        end else begin
            if (done_en) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                    if (status[i] == done_tag) begin
                        status[i] <= '0;
                    end
                end
            end
            // a new producer overrides the clear
            if (set_en) begin
                status[disp_rd] <= disp_tag;
            end
        end
    end

    // mask a producer that completes this cycle so its wakeup is not lost
    always_comb begin : source_tags
        raw_t1 = status[disp_rs1];
        raw_t2 = status[disp_rs2];
        src_t1 = (done_en && raw_t1 == done_tag) ? '0 : raw_t1;
        src_t2 = (done_en && raw_t2 == done_tag) ? '0 : raw_t2;
    end

endmodule

`default_nettype wire

// ==== design/fust.sv ====
//--------------------------------------
// function unit status table, one row per scalar unit,
// written by dispatch, tags cleared on completion
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fust import issue_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            wr_en,
    input  fu_e             wr_fu,
    input  reg_addr_t       wr_rd,
    input  reg_addr_t       wr_rs1,
    input  reg_addr_t       wr_rs2,
    input  tag_t            wr_t1,
    input  tag_t            wr_t2,
    input  logic            done_en,
    input  fu_e             done_fu,
    output reg_addr_t [2:0] row_rd,
    output reg_addr_t [2:0] row_rs1,
    output reg_addr_t [2:0] row_rs2,
    output tag_t      [2:0] row_t1,
    output tag_t      [2:0] row_t2
);

    tag_t       done_tag;
    logic [2:0] row_wr;

    assign done_tag = tag_t'(done_fu) + tag_t'(1);

    // row select from the unit number
    always_comb begin : row_decode
        for (int i = 0; i < 3; i++) begin
            row_wr[i] = wr_en && (wr_fu == fu_e'(i));
        end
    end

    always_ff @(posedge CLK) begin : row_fields
        for (int i = 0; i < 3; i++) begin
            if (row_wr[i]) begin
                row_rd[i]  <= wr_rd;
                row_rs1[i] <= wr_rs1;
                row_rs2[i] <= wr_rs2;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin : row_tags
        if (!nRST) begin
            row_t1 <= '0;
            row_t2 <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (row_wr[i]) begin
                    row_t1[i] <= wr_t1;
                    row_t2[i] <= wr_t2;
                end else if (done_en) begin
                    // wakeup of waiting sources
                    if (row_t1[i] == done_tag) begin
                        row_t1[i] <= '0;
                    end
                    if (row_t2[i] == done_tag) begin
                        row_t2[i] <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/issue.sv ====
//--------------------------------------
// issue stage: row FSMs, oldest-ready select, register read
// and the registered issue output held by freeze
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue import issue_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_en,
    input  fu_e               disp_fu,
    input  reg_addr_t         disp_rd,
    input  reg_addr_t         disp_rs1,
    input  reg_addr_t         disp_rs2,
    input  tag_t              src_t1,
    input  tag_t              src_t2,
    input  logic              done_en,
    input  fu_e               done_fu,
    input  logic [DATA_W-1:0] done_data,
    input  logic              freeze,
    output logic [2:0]        busy,
    output logic              iss_valid,
    output fu_e               iss_fu,
    output reg_addr_t         iss_rd,
    output logic [DATA_W-1:0] iss_rdat1,
    output logic [DATA_W-1:0] iss_rdat2
);

    reg_addr_t [2:0]   row_rd;
    reg_addr_t [2:0]   row_rs1;
    reg_addr_t [2:0]   row_rs2;
    tag_t      [2:0]   row_t1;
    tag_t      [2:0]   row_t2;
    fust_state_e       state [3];
    fust_state_e       next_state [3];
    age_t              age [3];
    logic [2:0]        disp_hit;
    logic [2:0]        done_hit;
    logic [2:0]        cand;
    logic              sel_valid;
    fu_e               sel_fu;
    age_t              sel_age;
    logic              go;
    logic              rf_wen;
    reg_addr_t         rf_wsel;
    logic [DATA_W-1:0] rf_rdat1;
    logic [DATA_W-1:0] rf_rdat2;

    regfile #(.DATA_W(DATA_W)) regfile_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (rf_wen),
        .wsel  (rf_wsel),
        .wdata (done_data),
        .rsel1 (row_rs1[sel_fu]),
        .rsel2 (row_rs2[sel_fu]),
        .rdat1 (rf_rdat1),
        .rdat2 (rf_rdat2)
    );

    fust fust_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .wr_en   (disp_en),
        .wr_fu   (disp_fu),
        .wr_rd   (disp_rd),
        .wr_rs1  (disp_rs1),
        .wr_rs2  (disp_rs2),
        .wr_t1   (src_t1),
        .wr_t2   (src_t2),
        .done_en (done_en),
        .done_fu (done_fu),
        .row_rd  (row_rd),
        .row_rs1 (row_rs1),
        .row_rs2 (row_rs2),
        .row_t1  (row_t1),
        .row_t2  (row_t2)
    );

    always_comb begin : row_decode
        for (int i = 0; i < 3; i++) begin
            disp_hit[i] = disp_en && (disp_fu == fu_e'(i));
            done_hit[i] = done_en && (done_fu == fu_e'(i));
            cand[i]     = (state[i] == FUST_WAIT || state[i] == FUST_RDY) &&
                          row_t1[i] == '0 && row_t2[i] == '0;
            busy[i]     = state[i] != FUST_EMPTY;
        end
    end

    // largest age wins, strict compare keeps the lowest index on a tie
    always_comb begin : oldest_select
        sel_valid = 1'b0;
        sel_fu    = FU_ALU;
        sel_age   = '0;
        for (int i = 0; i < 3; i++) begin
            if (cand[i] && (!sel_valid || age[i] > sel_age)) begin
                sel_valid = 1'b1;
                sel_fu    = fu_e'(i);
                sel_age   = age[i];
            end
        end
    end

    assign go = sel_valid && !freeze;

    // completing unit writes back, branch has no destination
    always_comb begin : write_port
        rf_wen  = 1'b0;
        rf_wsel = row_rd[FU_ALU];
        if (done_en && (done_fu == FU_ALU || done_fu == FU_LDST)) begin
            rf_wen  = 1'b1;
            rf_wsel = row_rd[done_fu];
        end
    end

    always_comb begin : row_next_state
        for (int i = 0; i < 3; i++) begin
            next_state[i] = state[i];
            case (state[i])
                FUST_EMPTY: begin
                    if (disp_hit[i]) begin
                        next_state[i] = FUST_WAIT;
                    end
                end
                FUST_WAIT, FUST_RDY: begin
                    if (go && sel_fu == fu_e'(i)) begin
                        next_state[i] = FUST_EX;
                    end else if (go && cand[i]) begin
                        next_state[i] = FUST_RDY;
                    end
                end
                FUST_EX: begin
                    if (done_hit[i]) begin
                        next_state[i] = disp_hit[i] ? FUST_WAIT : FUST_EMPTY;
                    end
                end
                default: next_state[i] = FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin : row_state_reg
        if (!nRST) begin
            for (int i = 0; i < 3; i++) begin
                state[i] <= FUST_EMPTY;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                state[i] <= next_state[i];
            end
        end
    end

    // new row starts at 1, waiting rows age on every dispatch
    always_ff @(posedge CLK or negedge nRST) begin : row_age_reg
        if (!nRST) begin
            for (int i = 0; i < 3; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (disp_hit[i]) begin
                    age[i] <= age_t'(1);
                end else if (|disp_hit && (state[i] == FUST_WAIT || state[i] == FUST_RDY) &&
                             age[i] != '1) begin
                    age[i] <= age[i] + age_t'(1);
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin : issue_valid_reg
        if (!nRST) begin
            iss_valid <= 1'b0;
        end else if (!freeze) begin
            iss_valid <= go;
        end
    end

    always_ff @(posedge CLK) begin : issue_payload_reg
        if (go) begin
            iss_fu    <= sel_fu;
            iss_rd    <= row_rd[sel_fu];
            iss_rdat1 <= rf_rdat1;
            iss_rdat2 <= rf_rdat2;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_top.sv ====
//--------------------------------------
// issue stage top, joins the register status table and
// the issue stage to the dispatch and completion ports
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue_top import issue_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    // dispatch
    input  logic              disp_en,
    input  fu_e               disp_fu,
    input  reg_addr_t         disp_rd,
    input  reg_addr_t         disp_rs1,
    input  reg_addr_t         disp_rs2,
    // completion
    input  logic              done_en,
    input  fu_e               done_fu,
    input  logic [DATA_W-1:0] done_data,
    input  logic              freeze,
    output logic [2:0]        busy,
    // issue to execute
    output logic              iss_valid,
    output fu_e               iss_fu,
    output reg_addr_t         iss_rd,
    output logic [DATA_W-1:0] iss_rdat1,
    output logic [DATA_W-1:0] iss_rdat2
);

    // source tags for the row being dispatched
    tag_t src_t1;
    tag_t src_t2;

    reg_status reg_status_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .disp_en  (disp_en),
        .disp_fu  (disp_fu),
        .disp_rd  (disp_rd),
        .disp_rs1 (disp_rs1),
        .disp_rs2 (disp_rs2),
        .done_en  (done_en),
        .done_fu  (done_fu),
        .src_t1   (src_t1),
        .src_t2   (src_t2)
    );

    issue #(.DATA_W(DATA_W)) issue_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp_en   (disp_en),
        .disp_fu   (disp_fu),
        .disp_rd   (disp_rd),
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .src_t1    (src_t1),
        .src_t2    (src_t2),
        .done_en   (done_en),
        .done_fu   (done_fu),
        .done_data (done_data),
        .freeze    (freeze),
        .busy      (busy),
        .iss_valid (iss_valid),
        .iss_fu    (iss_fu),
        .iss_rd    (iss_rd),
        .iss_rdat1 (iss_rdat1),
        .iss_rdat2 (iss_rdat2)
    );

endmodule

`default_nettype wire

// ==== testbench/issue_tb.sv ====
//--------------------------------------
// directed testbench for the issue stage top level,
// with a register model, a timeout and one result line
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module issue_tb import issue_pkg::*;;

    localparam int DATA_W = 32;
    localparam int TIMEOUT_CYCLES = 2000;

    logic              CLK;
    logic              nRST;
    logic              disp_en;
    fu_e               disp_fu;
    reg_addr_t         disp_rd;
    reg_addr_t         disp_rs1;
    reg_addr_t         disp_rs2;
    logic              done_en;
    fu_e               done_fu;
    logic [DATA_W-1:0] done_data;
    logic              freeze;
    logic [2:0]        busy;
    logic              iss_valid;
    fu_e               iss_fu;
    reg_addr_t         iss_rd;
    logic [DATA_W-1:0] iss_rdat1;
    logic [DATA_W-1:0] iss_rdat2;

    // expected register values and the rd held by each row
    logic [DATA_W-1:0] model [NUM_REGS];
    reg_addr_t         pend_rd [3];
    integer            seed;
    int                errors;
    int                checks;
    int                cycles;

    issue_top #(.DATA_W(DATA_W)) issue_top_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp_en   (disp_en),
        .disp_fu   (disp_fu),
        .disp_rd   (disp_rd),
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .done_en   (done_en),
        .done_fu   (done_fu),
        .done_data (done_data),
        .freeze    (freeze),
        .busy      (busy),
        .iss_valid (iss_valid),
        .iss_fu    (iss_fu),
        .iss_rd    (iss_rd),
        .iss_rdat1 (iss_rdat1),
        .iss_rdat2 (iss_rdat2)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic dispatch_op(input fu_e fu, input reg_addr_t rd, input reg_addr_t rs1,
                               input reg_addr_t rs2);
        disp_en  = 1'b1;
        disp_fu  = fu;
        disp_rd  = rd;
        disp_rs1 = rs1;
        disp_rs2 = rs2;
        step_cycle();
        disp_en     = 1'b0;
        pend_rd[fu] = rd;
    endtask

    // branch completions and rd 0 leave the registers alone
    task automatic complete_op(input fu_e fu, input logic [DATA_W-1:0] data);
        done_en   = 1'b1;
        done_fu   = fu;
        done_data = data;
        step_cycle();
        done_en = 1'b0;
        if (fu != FU_BRANCH && pend_rd[fu] != '0) begin
            model[pend_rd[fu]] = data;
        end
    endtask

    task automatic wait_for_issue(input string name, input int limit);
        int n;
        n = 0;
        while (iss_valid !== 1'b1 && n < limit) begin
            step_cycle();
            n++;
        end
        checks++;
        if (iss_valid !== 1'b1) begin
            errors++;
            $display("%s: no issue seen within %0d cycles", name, limit);
        end
    endtask

    task automatic check_issue(input string name, input fu_e fu, input reg_addr_t rd,
                               input reg_addr_t rs1, input reg_addr_t rs2);
        compare_value({name, " iss_valid"}, 32'd1, 32'(iss_valid));
        compare_value({name, " iss_fu"}, 32'(fu), 32'(iss_fu));
        compare_value({name, " iss_rd"}, 32'(rd), 32'(iss_rd));
        compare_value({name, " iss_rdat1"}, model[rs1], iss_rdat1);
        compare_value({name, " iss_rdat2"}, model[rs2], iss_rdat2);
    endtask

    task automatic reset_state_check();
        compare_value("reset busy", 32'd0, 32'(busy));
        compare_value("reset iss_valid", 32'd0, 32'(iss_valid));
    endtask

    // clear sources, issue exactly two edges after dispatch
    task automatic independent_issue();
        logic [DATA_W-1:0] data;
        dispatch_op(FU_ALU, 5'd5, 5'd3, 5'd4);
        compare_value("independent early", 32'd0, 32'(iss_valid));
        step_cycle();
        check_issue("independent", FU_ALU, 5'd5, 5'd3, 5'd4);
        data = $random(seed);
        complete_op(FU_ALU, data);
        compare_value("independent busy", 32'd0, 32'(busy[0]));
    endtask

    task automatic raw_dependence();
        logic [DATA_W-1:0] data;
        dispatch_op(FU_LDST, 5'd7, 5'd5, 5'd0);
        step_cycle();
        check_issue("raw producer", FU_LDST, 5'd7, 5'd5, 5'd0);
        dispatch_op(FU_ALU, 5'd9, 5'd7, 5'd5);
        // consumer stays blocked while the load/store runs
        repeat (4) begin
            step_cycle();
            compare_value("raw blocked", 32'd0, 32'(iss_valid));
        end
        data = $random(seed);
        complete_op(FU_LDST, data);
        compare_value("raw at completion", 32'd0, 32'(iss_valid));
        wait_for_issue("raw consumer", 1);
        check_issue("raw consumer", FU_ALU, 5'd9, 5'd7, 5'd5);
        compare_value("raw forwarded data", data, iss_rdat1);
        data = $random(seed);
        complete_op(FU_ALU, data);
    endtask

    task automatic oldest_first();
        logic [DATA_W-1:0] data;
        dispatch_op(FU_LDST, 5'd10, 5'd0, 5'd0);
        step_cycle();
        check_issue("oldest producer", FU_LDST, 5'd10, 5'd0, 5'd0);
        dispatch_op(FU_ALU, 5'd11, 5'd10, 5'd9);
        dispatch_op(FU_BRANCH, 5'd0, 5'd10, 5'd7);
        compare_value("oldest busy", 32'd7, 32'(busy));
        compare_value("oldest blocked", 32'd0, 32'(iss_valid));
        data = $random(seed);
        complete_op(FU_LDST, data);
        step_cycle();
        check_issue("oldest alu", FU_ALU, 5'd11, 5'd10, 5'd9);
        step_cycle();
        check_issue("oldest branch", FU_BRANCH, 5'd0, 5'd10, 5'd7);
        data = $random(seed);
        complete_op(FU_ALU, data);
        data = $random(seed);
        complete_op(FU_BRANCH, data);
        compare_value("oldest idle", 32'd0, 32'(busy));
        // an older branch row wins over a younger ALU row
        dispatch_op(FU_LDST, 5'd12, 5'd0, 5'd0);
        step_cycle();
        check_issue("age producer", FU_LDST, 5'd12, 5'd0, 5'd0);
        dispatch_op(FU_BRANCH, 5'd0, 5'd12, 5'd0);
        dispatch_op(FU_ALU, 5'd16, 5'd12, 5'd0);
        data = $random(seed);
        complete_op(FU_LDST, data);
        step_cycle();
        check_issue("age branch", FU_BRANCH, 5'd0, 5'd12, 5'd0);
        step_cycle();
        check_issue("age alu", FU_ALU, 5'd16, 5'd12, 5'd0);
        data = $random(seed);
        complete_op(FU_BRANCH, data);
        data = $random(seed);
        complete_op(FU_ALU, data);
    endtask

    // freeze rises while an issue is shown, so valid and payload must hold
    task automatic freeze_hold();
        logic              held_valid;
        fu_e               held_fu;
        reg_addr_t         held_rd;
        logic [DATA_W-1:0] held_d1;
        logic [DATA_W-1:0] held_d2;
        logic [DATA_W-1:0] data;
        dispatch_op(FU_ALU, 5'd15, 5'd9, 5'd11);
        step_cycle();
        check_issue("freeze first", FU_ALU, 5'd15, 5'd9, 5'd11);
        freeze     = 1'b1;
        held_valid = iss_valid;
        held_fu    = iss_fu;
        held_rd    = iss_rd;
        held_d1    = iss_rdat1;
        held_d2    = iss_rdat2;
        dispatch_op(FU_LDST, 5'd14, 5'd11, 5'd10);
        repeat (5) begin
            step_cycle();
            compare_value("freeze iss_valid", 32'(held_valid), 32'(iss_valid));
            compare_value("freeze iss_fu", 32'(held_fu), 32'(iss_fu));
            compare_value("freeze iss_rd", 32'(held_rd), 32'(iss_rd));
            compare_value("freeze iss_rdat1", held_d1, iss_rdat1);
            compare_value("freeze iss_rdat2", held_d2, iss_rdat2);
            compare_value("freeze busy", 32'd1, 32'(busy[1]));
        end
        freeze = 1'b0;
        step_cycle();
        check_issue("freeze release", FU_LDST, 5'd14, 5'd11, 5'd10);
        data = $random(seed);
        complete_op(FU_ALU, data);
        data = $random(seed);
        complete_op(FU_LDST, data);
    endtask

    task automatic reg_zero_read();
        logic [DATA_W-1:0] data;
        dispatch_op(FU_ALU, 5'd0, 5'd0, 5'd0);
        step_cycle();
        check_issue("reg0 writer", FU_ALU, 5'd0, 5'd0, 5'd0);
        data = $random(seed);
        complete_op(FU_ALU, data | 32'd1);
        dispatch_op(FU_LDST, 5'd13, 5'd0, 5'd0);
        step_cycle();
        check_issue("reg0 reader", FU_LDST, 5'd13, 5'd0, 5'd0);
        compare_value("reg0 value", 32'd0, iss_rdat1);
        data = $random(seed);
        complete_op(FU_LDST, data);
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        disp_en   = 1'b0;
        disp_fu   = FU_ALU;
        disp_rd   = '0;
        disp_rs1  = '0;
        disp_rs2  = '0;
        done_en   = 1'b0;
        done_fu   = FU_ALU;
        done_data = '0;
        freeze    = 1'b0;
        seed      = 32'h29ab;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            pend_rd[i] = '0;
        end
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        reset_state_check();
        independent_issue();
        raw_dependence();
        oldest_first();
        freeze_hold();
        reg_zero_read();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/issue_pkg.sv
design/regfile.sv
design/reg_status.sv
design/fust.sv
design/issue.sv
design/issue_top.sv
testbench/issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module issue_tb -o issue_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/issue_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '>>> PASS' "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
